// File: flist.f
logic/fetch_pkg.sv
logic/fetch_line_requester.sv
logic/fetch_line_buffer.sv
logic/fetch_aligner.sv
logic/fetch_unit.sv
tb/icache_model.sv
tb/fetch_unit_tb.sv

// File: logic/fetch_aligner.sv
// byte aligner presenting the 16-byte window at the read point and the instruction eip
`timescale 1ns/1ps

module fetch_aligner (
   input  logic                         CLK,
   input  logic                         reset,
   input  fetch_pkg::redirect_t         redirect,
   input  fetch_pkg::line_t             line_cur,
   input  fetch_pkg::line_t             line_next,
   input  logic [fetch_pkg::len_w-1:0]  offset,
   input  logic                         bytes_avail_ok,
   input  fetch_pkg::take_t             take,
   output fetch_pkg::line_t             window,
   output logic                         window_valid,
   output logic [fetch_pkg::addr_w-1:0] eip_out,
   output fetch_pkg::take_t             take_ok
);
   import fetch_pkg::*;

   logic [2*line_w-1:0] line_pair;
   logic [2*line_w-1:0] line_shifted;
   logic [addr_w-1:0]   eip_q;

   // next line sits above current, so a right shift walks forward in memory
   assign line_pair = {line_next, line_cur};
   assign line_shifted = line_pair >> {offset, 3'b000};
   assign window = line_shifted[line_w-1:0];

   assign window_valid = bytes_avail_ok;

   // takes without a full window are dropped here
   assign take_ok.valid = take.valid && bytes_avail_ok;
   assign take_ok.len = take.len;

   assign eip_out = eip_q;

   always_ff @(posedge CLK) begin
      if (reset) begin
         eip_q <= '0;
      end else if (redirect.valid) begin
         eip_q <= redirect.eip;
      end else if (take_ok.valid) begin
         eip_q <= eip_q + addr_w'(take_ok.len);
      end
   end

endmodule

// File: logic/fetch_line_buffer.sv
// four-line prefetch ring with write pointer, byte read pointer and fill tracking
`timescale 1ns/1ps

module fetch_line_buffer (
   input  logic                        CLK,
   input  logic                        reset,
   input  logic                        redirect_valid,
   input  logic                        line_wr_valid,
   input  fetch_pkg::line_t            line_wr_data,
   input  fetch_pkg::take_t            take,
   output logic                        has_space,
   output fetch_pkg::line_t            line_cur,
   output fetch_pkg::line_t            line_next,
   output logic [fetch_pkg::len_w-1:0] offset,
   output logic                        bytes_avail_ok
);
   import fetch_pkg::*;

   line_t            ring [buf_lines];
   logic [idx_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w-1:0] rd_ptr_next;
   logic [cnt_w-1:0] count;
   logic [cnt_w-1:0] count_next;
   logic [idx_w-1:0] rd_line;
   logic [idx_w-1:0] rd_line_next;
   logic [len_w:0]   offset_sum;
   logic             line_freed;
   logic [ptr_w:0]   avail_bytes;

   // upper bits pick the line, lower bits the byte inside it
   assign rd_line = rd_ptr[ptr_w-1:len_w];
   assign rd_line_next = rd_line + idx_w'(1);
   assign offset = rd_ptr[len_w-1:0];

   assign line_cur = ring[rd_line];
   assign line_next = ring[rd_line_next];

   // take is already gated by availability in the aligner
   assign rd_ptr_next = take.valid ? rd_ptr + ptr_w'(take.len) : rd_ptr;

   // carry out of the byte offset means the current line is used up
   assign offset_sum = {1'b0, offset} + {1'b0, take.len};
   assign line_freed = take.valid && offset_sum[len_w];

   assign count_next = count + cnt_w'(line_wr_valid) - cnt_w'(line_freed);

   // line being written counts as stored, frees this cycle do not
   assign has_space = (count + cnt_w'(line_wr_valid)) < cnt_w'(buf_lines);

   // bytes past the read point, count includes the partly read line
   assign avail_bytes = {count, {len_w{1'b0}}} - {{cnt_w{1'b0}}, offset};
   assign bytes_avail_ok = avail_bytes >= (ptr_w + 1)'(line_bytes);

   always_ff @(posedge CLK) begin
      if (line_wr_valid) begin
         ring[wr_ptr] <= line_wr_data;
      end
   end

   // redirect drops every stored line
   always_ff @(posedge CLK) begin
      if (reset || redirect_valid) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (line_wr_valid) begin
            wr_ptr <= wr_ptr + idx_w'(1);
         end
         rd_ptr <= rd_ptr_next;
         count <= count_next;
      end
   end

endmodule

// File: logic/fetch_line_requester.sv
// fetch state machine issuing 16-byte line requests to the instruction cache
`timescale 1ns/1ps

module fetch_line_requester (
   input  logic                   CLK,
   input  logic                   reset,
   input  fetch_pkg::redirect_t   redirect,
   input  fetch_pkg::icache_rsp_t icache_rsp,
   input  logic                   has_space,
   output fetch_pkg::icache_req_t icache_req,
   output logic                   line_wr_valid,
   output fetch_pkg::line_t       line_wr_data
);
   import fetch_pkg::*;

   fetch_state_e      state;
   fetch_state_e      state_next;
   logic [addr_w-1:0] fetch_ptr;
   logic [addr_w-1:0] fetch_ptr_next;
   logic [addr_w-1:0] restart_ptr;
   logic [addr_w-1:0] restart_ptr_next;
   logic [addr_w-1:0] redirect_linear;
   logic              req_en;

   // linear = eip + segment base, base is the selector shifted up 16
   assign redirect_linear = redirect.eip + {redirect.cs, {(addr_w - cs_w){1'b0}}};

   // a request is open in st_fill and while draining a stale one in st_flush
   assign req_en = (state == st_fill) || (state == st_flush);

   assign icache_req.en = req_en;
   assign icache_req.addr = fetch_ptr;

   // stale data in st_flush and data racing a redirect never reach the ring
   assign line_wr_valid = (state == st_fill) && icache_rsp.ready && !redirect.valid;
   assign line_wr_data = icache_rsp.data;

   always_comb begin
      state_next = state;
      fetch_ptr_next = fetch_ptr;
      restart_ptr_next = restart_ptr;
      if (redirect.valid) begin
         if (req_en && !icache_rsp.ready) begin
            // cache still owes us a line, wait for it before moving
            state_next = st_flush;
            restart_ptr_next = redirect_linear;
         end else begin
            state_next = st_fill;
            fetch_ptr_next = redirect_linear;
         end
      end else begin
         case (state)
            st_reset: begin
               state_next = st_fill;
            end
            st_fill: begin
               if (icache_rsp.ready) begin
                  fetch_ptr_next = fetch_ptr + addr_w'(line_bytes);
                  // has_space already counts the line landing now
                  if (!has_space) begin
                     state_next = st_full;
                  end
               end
            end
            st_full: begin
               if (has_space) begin
                  state_next = st_fill;
               end
            end
            st_flush: begin
               if (icache_rsp.ready) begin
                  fetch_ptr_next = restart_ptr;
                  state_next = st_fill;
               end
            end
            default: begin
               state_next = st_reset;
            end
         endcase
      end
   end

   // eip 0 and cs 0 give linear address 0 out of reset
   always_ff @(posedge CLK) begin
      if (reset) begin
         state <= st_reset;
         fetch_ptr <= '0;
      end else begin
         state <= state_next;
         fetch_ptr <= fetch_ptr_next;
      end
   end

   // where to resume once the stale response is dropped
   always_ff @(posedge CLK) begin
      restart_ptr <= restart_ptr_next;
   end

endmodule

// File: logic/fetch_pkg.sv
// fetch unit package with widths, ring depth, bus structs and the fetch state enum
package fetch_pkg;

   // line and window geometry
   localparam int line_bytes = 16;
   localparam int line_w = 8 * line_bytes;
   localparam int buf_lines = 4;

   // byte read pointer spans the whole ring
   localparam int len_w = 4;
   localparam int ptr_w = 6;
   localparam int idx_w = ptr_w - len_w;
   localparam int cnt_w = $clog2(buf_lines + 1);

   localparam int addr_w = 32;
   localparam int cs_w = 16;

   typedef logic [line_w-1:0] line_t;

   // cache side, en and addr stay put until ready
   typedef struct packed {
      logic              en;
      logic [addr_w-1:0] addr;
   } icache_req_t;

   typedef struct packed {
      logic  ready;
      line_t data;
   } icache_rsp_t;

   // jump or exception restart
   typedef struct packed {
      logic              valid;
      logic [addr_w-1:0] eip;
      logic [cs_w-1:0]   cs;
   } redirect_t;

   // length of the instruction downstream consumed
   typedef struct packed {
      logic             valid;
      logic [len_w-1:0] len;
   } take_t;

   typedef enum logic [1:0] {
      st_reset,
      st_fill,
      st_full,
      st_flush
   } fetch_state_e;

endpackage

// File: logic/fetch_unit.sv
// instruction fetch front end with line requester, prefetch ring and byte aligner
`timescale 1ns/1ps

module fetch_unit (
   input  logic                         CLK,
   input  logic                         reset,
   input  fetch_pkg::redirect_t         redirect,
   input  fetch_pkg::icache_rsp_t       icache_rsp,
   input  fetch_pkg::take_t             take,
   output fetch_pkg::icache_req_t       icache_req,
   output fetch_pkg::line_t             window,
   output logic                         window_valid,
   output logic [fetch_pkg::addr_w-1:0] eip_out
);
   import fetch_pkg::*;

   logic             has_space;
   logic             line_wr_valid;
   line_t            line_wr_data;
   line_t            line_cur;
   line_t            line_next;
   logic [len_w-1:0] offset;
   logic             bytes_avail_ok;
   take_t            take_ok;

   fetch_line_requester u_requester (
      .CLK           (CLK),
      .reset         (reset),
      .redirect      (redirect),
      .icache_rsp    (icache_rsp),
      .has_space     (has_space),
      .icache_req    (icache_req),
      .line_wr_valid (line_wr_valid),
      .line_wr_data  (line_wr_data)
   );

   fetch_line_buffer u_buffer (
      .CLK            (CLK),
      .reset          (reset),
      .redirect_valid (redirect.valid),
      .line_wr_valid  (line_wr_valid),
      .line_wr_data   (line_wr_data),
      .take           (take_ok),
      .has_space      (has_space),
      .line_cur       (line_cur),
      .line_next      (line_next),
      .offset         (offset),
      .bytes_avail_ok (bytes_avail_ok)
   );

   fetch_aligner u_aligner (
      .CLK            (CLK),
      .reset          (reset),
      .redirect       (redirect),
      .line_cur       (line_cur),
      .line_next      (line_next),
      .offset         (offset),
      .bytes_avail_ok (bytes_avail_ok),
      .take           (take),
      .window         (window),
      .window_valid   (window_valid),
      .eip_out        (eip_out),
      .take_ok        (take_ok)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# compile the fetch unit testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
   --top-module fetch_unit_tb \
   -f flist.f \
   -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
   echo "fetch unit simulation reported failure"
   exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
   echo "fetch unit simulation ended without a result"
   exit 1
fi

// File: tb/fetch_unit_tb.sv
// testbench for the fetch unit with a random take stream, redirects and a reference model
`timescale 1ns/1ps

module fetch_unit_tb;
   import fetch_pkg::*;

   localparam int planned_takes = 300 + 120 + 40;
   localparam int timeout_cycles = 40 * planned_takes + 200;

   logic              CLK;
   logic              reset;
   redirect_t         redirect;
   icache_rsp_t       icache_rsp;
   take_t             take;
   icache_req_t       icache_req;
   line_t             window;
   logic              window_valid;
   logic [addr_w-1:0] eip_out;
   logic [1:0]        ready_delay;
   logic              stall;

   // reference model state
   logic [addr_w-1:0] m_eip;
   logic [cs_w-1:0]   m_cs;
   logic [addr_w-1:0] exp_req;
   logic              skip_stale;
   logic              checks_on;
   logic [31:0]       lfsr;
   int                takes_done;
   int                errors;
   int                tests_run;
   int                tests_failed;
   int                cycles;

   fetch_unit dut (
      .CLK          (CLK),
      .reset        (reset),
      .redirect     (redirect),
      .icache_rsp   (icache_rsp),
      .take         (take),
      .icache_req   (icache_req),
      .window       (window),
      .window_valid (window_valid),
      .eip_out      (eip_out)
   );

   icache_model icache (
      .CLK         (CLK),
      .reset       (reset),
      .req         (icache_req),
      .ready_delay (ready_delay),
      .stall       (stall),
      .rsp         (icache_rsp)
   );

   always #50 CLK = ~CLK;

   // galois lfsr stepped once per random bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [len_w-1:0] rand_len();
      logic [31:0] r;
      r = rand_bits(4);
      return len_w'((r % 32'd15) + 32'd1);
   endfunction

   function automatic line_t expected_window(input logic [addr_w-1:0] lin);
      line_t             l;
      logic [addr_w-1:0] a;
      l = '0;
      for (int k = 0; k < line_bytes; k++) begin
         a = lin + addr_w'(k);
         l[8*k +: 8] = a[7:0] ^ a[15:8];
      end
      return l;
   endfunction

   function automatic logic [addr_w-1:0] linear_of(input logic [addr_w-1:0] eip,
                                                   input logic [cs_w-1:0] cs);
      return eip + {cs, 16'h0000};
   endfunction

   // request order, lookahead and eip model sampled at the rising edge
   always @(posedge CLK) begin
      cycles++;
      if (cycles > timeout_cycles) begin
         $display("timeout: run went past %0d cycles", timeout_cycles);
         $display("Simulation FAILED");
         $finish;
      end else if (!reset) begin
         if (redirect.valid) begin
            m_eip = redirect.eip;
            m_cs = redirect.cs;
            exp_req = linear_of(redirect.eip, redirect.cs);
            // an open request at redirect time returns one stale line
            skip_stale = icache_req.en && !icache_rsp.ready;
         end else begin
            if (icache_req.en && icache_rsp.ready) begin
               if (skip_stale) begin
                  skip_stale = 1'b0;
               end else begin
                  assert (icache_req.addr == exp_req) else begin
                     $display("Fail icache_req.addr: got %h expected %h",
                              icache_req.addr, exp_req);
                     errors++;
                  end
                  assert (icache_req.addr - linear_of(m_eip, m_cs) <= 32'd64) else begin
                     $display("request at %h ran more than four lines ahead of %h",
                              icache_req.addr, linear_of(m_eip, m_cs));
                     errors++;
                  end
                  exp_req = exp_req + 32'd16;
               end
            end
            if (take.valid && window_valid) begin
               m_eip = m_eip + addr_w'(take.len);
               takes_done++;
            end
         end
      end
   end

   // window and eip checks where DUT outputs are stable
   always @(negedge CLK) begin
      if (checks_on) begin
         assert (eip_out == m_eip) else begin
            $display("Fail eip_out: got %h expected %h", eip_out, m_eip);
            errors++;
         end
         if (window_valid) begin
            assert (window == expected_window(linear_of(m_eip, m_cs))) else begin
               $display("Fail window: got %h expected %h", window,
                        expected_window(linear_of(m_eip, m_cs)));
               errors++;
            end
         end
      end
   end

   task automatic next_cycle();
      @(negedge CLK);
      ready_delay <= 2'(rand_bits(2));
      redirect <= '0;
      take <= '0;
   endtask

   task automatic issue_redirect();
      logic [addr_w-1:0] eip;
      logic [cs_w-1:0]   cs;
      eip = rand_bits(32);
      cs = cs_w'(rand_bits(16));
      redirect <= {1'b1, eip, cs};
   endtask

   task automatic run_stream(input int n, input logic with_redirects);
      int target;
      int gap;
      target = takes_done + n;
      gap = 0;
      while (takes_done < target) begin
         next_cycle();
         if (with_redirects && rand_bits(5) == 32'd0) begin
            issue_redirect();
         end else if (gap != 0) begin
            gap--;
         end else begin
            take <= {1'b1, rand_len()};
            gap = int'(rand_bits(2));
         end
      end
      next_cycle();
   endtask

   task automatic hold_back();
      line_t             held_window;
      logic [addr_w-1:0] held_eip;
      while (!window_valid) begin
         next_cycle();
      end
      held_eip = m_eip;
      held_window = expected_window(linear_of(m_eip, m_cs));
      repeat (30) begin
         next_cycle();
         assert (window_valid) else begin
            $display("window_valid dropped while downstream took nothing");
            errors++;
         end
         assert (window == held_window) else begin
            $display("Fail window: got %h expected %h", window, held_window);
            errors++;
         end
         assert (eip_out == held_eip) else begin
            $display("Fail eip_out: got %h expected %h", eip_out, held_eip);
            errors++;
         end
      end
   endtask

   task automatic redirect_outstanding();
      stall <= 1'b1;
      next_cycle();
      next_cycle();
      // keep taking so the requester leaves st_full and raises en
      while (!(icache_req.en && !icache_rsp.ready)) begin
         next_cycle();
         take <= {1'b1, rand_len()};
      end
      next_cycle();
      issue_redirect();
      repeat (3) begin
         next_cycle();
      end
      stall <= 1'b0;
      run_stream(40, 1'b0);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
      end
   endtask

   initial begin
      int e;
      CLK = 1'b0;
      reset = 1'b1;
      redirect = '0;
      take = '0;
      stall = 1'b0;
      ready_delay = 2'd0;
      lfsr = 32'd71339;
      m_eip = '0;
      m_cs = '0;
      exp_req = '0;
      skip_stale = 1'b0;
      checks_on = 1'b0;
      takes_done = 0;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      cycles = 0;

      repeat (3) begin
         @(negedge CLK);
      end
      e = errors;
      assert (!icache_req.en && !window_valid && eip_out == '0) else begin
         $display("Fail reset: icache_req.en %h window_valid %h eip_out %h expected 0",
                  icache_req.en, window_valid, eip_out);
         errors++;
      end
      reset <= 1'b0;
      checks_on <= 1'b1;
      report_test("reset state", e);

      e = errors;
      run_stream(300, 1'b0);
      report_test("sequential stream", e);

      e = errors;
      hold_back();
      report_test("back-pressure", e);

      e = errors;
      run_stream(120, 1'b1);
      report_test("random redirects", e);

      e = errors;
      redirect_outstanding();
      report_test("redirect with open request", e);

      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: tb/icache_model.sv
// instruction cache responder with address-derived data and a variable ready delay
`timescale 1ns/1ps

module icache_model (
   input  logic                   CLK,
   input  logic                   reset,
   input  fetch_pkg::icache_req_t req,
   input  logic [1:0]             ready_delay,
   input  logic                   stall,
   output fetch_pkg::icache_rsp_t rsp
);
   import fetch_pkg::*;

   logic       active;
   logic [1:0] wait_cnt;

   // byte at address a is the low byte of a xor (a >> 8)
   function automatic line_t line_at(input logic [addr_w-1:0] addr);
      line_t             l;
      logic [addr_w-1:0] a;
      l = '0;
      for (int k = 0; k < line_bytes; k++) begin
         a = addr + addr_w'(k);
         l[8*k +: 8] = a[7:0] ^ a[15:8];
      end
      return l;
   endfunction

   // idle response before the first falling edge
   initial begin
      rsp <= '0;
   end

   // responses change on the falling edge away from the DUT sampling edge
   always @(negedge CLK) begin
      if (reset || !req.en) begin
         active <= 1'b0;
         wait_cnt <= 2'd0;
         rsp <= '0;
      end else if (!active || rsp.ready) begin
         // new request once the previous one was accepted or none was open
         active <= 1'b1;
         wait_cnt <= ready_delay;
         rsp <= {(ready_delay == 2'd0) && !stall, line_at(req.addr)};
      end else begin
         if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end
         rsp <= {(wait_cnt <= 2'd1) && !stall, line_at(req.addr)};
      end
   end

endmodule
